/* ins_extract_top.f */
+incdir+include
logic/extract_pkg.sv
logic/slot_bus_if.sv
logic/line_aligner.sv
logic/slot_mux.sv
logic/bsr_detect.sv
logic/ins_extract_top.sv
tb/tb_ins_extract_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles and runs the extract stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Some tests failed"

if ! verilator --binary --timing -f ins_extract_top.f \
	--top-module tb_ins_extract_top -o sim_tb; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* tb/tb_ins_extract_top.sv */
// Random-stimulus testbench for the extract stage that is compiled with the RTL through the file list
`timescale 1ns/10ps
`include "extract_consts.svh"

module tb_ins_extract_top;

	localparam int NS = `EXT_SLOTS;
	localparam int IW = `EXT_INS_W;

	logic clk;
	logic rst_i;
	logic en_i;
	logic nop_i;
	logic irq_req_i;
	logic [2:0] irq_lvl_i;
	logic [7:0] irq_vect_i;
	logic mipv_i;
	logic [`EXT_MIP_W-1:0] mip_i;
	logic [IW-1:0] mc_ins [0:NS-1];
	logic [`EXT_LINE_W-1:0] line_i;
	logic [`EXT_PC_W-1:0] pc_i;
	logic branch_miss_i;
	logic [`EXT_PC_W-1:0] miss_pc_i;

	wire [IW-1:0] ins_o [0:NS-1];
	wire [`EXT_PC_W-1:0] pc_o [0:NS-1];
	wire [`EXT_REG_W-1:0] rt_o [0:NS-1];
	wire [`EXT_REG_W-1:0] ra_o [0:NS-1];
	wire dead_o [0:NS-1];
	wire [`EXT_MIP_W-1:0] mcip_o [0:NS-1];
	wire nop_o;
	wire do_bsr_o;
	wire [`EXT_PC_W-1:0] bsr_tgt_o;

	// Expected registered state of the stage
	logic [IW-1:0] exp_ins [0:NS-1];
	logic [`EXT_PC_W-1:0] exp_pc [0:NS-1];
	logic exp_dead [0:NS-1];
	logic [`EXT_MIP_W-1:0] exp_mcip [0:NS-1];
	logic exp_nop;
	logic exp_do_bsr;
	logic [`EXT_PC_W-1:0] exp_tgt;

	ins_extract_top i_dut
	(
		.clk (clk), .rst_i (rst_i), .en_i (en_i), .nop_i (nop_i),
		.irq_req_i (irq_req_i), .irq_lvl_i (irq_lvl_i), .irq_vect_i (irq_vect_i),
		.mipv_i (mipv_i), .mip_i (mip_i),
		.mc_ins0_i (mc_ins[0]), .mc_ins1_i (mc_ins[1]),
		.mc_ins2_i (mc_ins[2]), .mc_ins3_i (mc_ins[3]),
		.line_i (line_i), .pc_i (pc_i),
		.branch_miss_i (branch_miss_i), .miss_pc_i (miss_pc_i),
		.ins0_o (ins_o[0]), .ins1_o (ins_o[1]), .ins2_o (ins_o[2]), .ins3_o (ins_o[3]),
		.pc0_o (pc_o[0]), .pc1_o (pc_o[1]), .pc2_o (pc_o[2]), .pc3_o (pc_o[3]),
		.rt0_o (rt_o[0]), .rt1_o (rt_o[1]), .rt2_o (rt_o[2]), .rt3_o (rt_o[3]),
		.ra0_o (ra_o[0]), .ra1_o (ra_o[1]), .ra2_o (ra_o[2]), .ra3_o (ra_o[3]),
		.dead0_o (dead_o[0]), .dead1_o (dead_o[1]),
		.dead2_o (dead_o[2]), .dead3_o (dead_o[3]),
		.mcip0_o (mcip_o[0]), .mcip1_o (mcip_o[1]),
		.mcip2_o (mcip_o[2]), .mcip3_o (mcip_o[3]),
		.nop_o (nop_o), .do_bsr_o (do_bsr_o), .bsr_tgt_o (bsr_tgt_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Overall limit in case the stimulus loop stops advancing
	initial
	begin
		#400000;
		$display("Simulation did not finish within the time limit");
		$display("Some tests failed");
		$fatal(1, "Timeout");
	end

	// ===================================================================
	// Reference model
	// ===================================================================

	// BSR search over the expected registered slots
	task automatic compute_group;
		logic found;
		found = 1'b0;
		exp_tgt = exp_pc[NS-1] + 32'd5;
		exp_nop = 1'b1;
		for (int k = 0; k < NS; k++)
		begin
			exp_nop = exp_nop & exp_dead[k];
			if (!found && exp_ins[k][6:0] == 7'(extract_pkg::OP_BSR))
			begin
				found = 1'b1;
				exp_tgt = exp_pc[k] + {{(`EXT_PC_W-30){exp_ins[k][IW-1]}}, exp_ins[k][IW-1:10]};
			end
		end
		exp_do_bsr = found;
	endtask

	task automatic reset_model;
		for (int k = 0; k < NS; k++)
		begin
			exp_ins[k] = '0;
			exp_pc[k] = '0;
			exp_dead[k] = 1'b1;
			exp_mcip[k] = '0;
		end
		compute_group();
	endtask

	// Next state for one enabled cycle from the inputs driven now
	task automatic update_model;
		logic [IW-1:0] raw;
		logic [IW-1:0] chk;
		logic [IW-1:0] sel;
		logic [`EXT_PC_W-1:0] spc;
		logic dead;
		for (int k = 0; k < NS; k++)
		begin
			spc = pc_i + 32'(5 * k);
			raw = IW'(line_i >> (8 * int'(pc_i[5:0]) + IW * k));
			chk = '0;
			chk[6:0] = 7'(extract_pkg::OP_CHK);
			chk[9:7] = irq_lvl_i;
			chk[39:32] = irq_vect_i;
			dead = 1'b0;
			if (irq_req_i && !mipv_i)
				sel = chk;
			else if (mipv_i)
				sel = mc_ins[k];
			else if (nop_i || (branch_miss_i && miss_pc_i > spc))
			begin
				sel = '0;
				dead = 1'b1;
			end
			else
				sel = raw;
			exp_ins[k] = sel;
			exp_pc[k] = spc;
			exp_dead[k] = dead;
			if (k == 0)
				exp_mcip[k] = mip_i;
			else if (mip_i == '0)
				exp_mcip[k] = '0;
			else
				exp_mcip[k] = mip_i | `EXT_MIP_W'(k);
		end
		compute_group();
	endtask

	// ===================================================================
	// Checks and stimulus
	// ===================================================================

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("error: %s is %h, expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_outputs;
		for (int k = 0; k < NS; k++)
		begin
			check_val($sformatf("ins%0d_o", k), 64'(ins_o[k]), 64'(exp_ins[k]));
			check_val($sformatf("pc%0d_o", k), 64'(pc_o[k]), 64'(exp_pc[k]));
			check_val($sformatf("rt%0d_o", k), 64'(rt_o[k]), 64'(exp_ins[k][12:7]));
			check_val($sformatf("ra%0d_o", k), 64'(ra_o[k]), 64'(exp_ins[k][18:13]));
			check_val($sformatf("dead%0d_o", k), 64'(dead_o[k]), 64'(exp_dead[k]));
			check_val($sformatf("mcip%0d_o", k), 64'(mcip_o[k]), 64'(exp_mcip[k]));
		end
		check_val("nop_o", 64'(nop_o), 64'(exp_nop));
		check_val("do_bsr_o", 64'(do_bsr_o), 64'(exp_do_bsr));
		check_val("bsr_tgt_o", 64'(bsr_tgt_o), 64'(exp_tgt));
	endtask

	// Runs one clock from 2 ns after an edge to 2 ns after the next one
	task automatic run_cycle;
		if (en_i)
			update_model();
		@(posedge clk);
		#1;
		check_outputs();
		#1;
	endtask

	task automatic apply_reset;
		int waited;
		rst_i = 1'b1;
		en_i = 1'(($urandom() % 2));
		repeat (5) @(posedge clk);
		waited = 0;
		while (nop_o !== 1'b1)
		begin
			if (waited == 4)
			begin
				$display("nop_o stayed low while reset was held");
				$display("Some tests failed");
				$fatal(1, "Reset did not take effect");
			end
			@(posedge clk);
			waited++;
		end
		#2;
		rst_i = 1'b0;
		reset_model();
		check_outputs();
	endtask

	task automatic base_inputs;
		en_i = 1'b1;
		nop_i = 1'b0;
		irq_req_i = 1'b0;
		mipv_i = 1'b0;
		branch_miss_i = 1'b0;
		irq_lvl_i = 3'($urandom());
		irq_vect_i = 8'($urandom());
		mip_i = `EXT_MIP_W'($urandom());
		pc_i = $urandom();
		miss_pc_i = $urandom();
		for (int k = 0; k < NS; k++)
			mc_ins[k] = {8'($urandom()), $urandom()};
		repeat (`EXT_LINE_W / 32) line_i = {line_i[`EXT_LINE_W-33:0], $urandom()};
	endtask

	// Writes four instructions into the line at an offset where all of them fit
	task automatic place_bsr;
		int ofs;
		logic [IW-1:0] ins;
		logic [`EXT_LINE_W-1:0] mask;
		ofs = int'($urandom() % 45);
		pc_i = {pc_i[`EXT_PC_W-1:6], 6'(ofs)};
		mask = `EXT_LINE_W'({IW{1'b1}});
		for (int k = 0; k < NS; k++)
		begin
			ins = {8'($urandom()), $urandom()};
			if ($urandom() % 3 == 0)
				ins[6:0] = 7'(extract_pkg::OP_BSR);
			line_i = (line_i & ~(mask << (8 * ofs + IW * k)))
				| (`EXT_LINE_W'(ins) << (8 * ofs + IW * k));
		end
	endtask

	initial
	begin
		void'($urandom(32'h4abd5d31));
		rst_i = 1'b1;
		line_i = '0;
		base_inputs();
		apply_reset();
		repeat (150)
		begin
			base_inputs();
			run_cycle();
		end
		// Branch misses around the slot PCs and then whole-group NOPs
		repeat (100)
		begin
			base_inputs();
			branch_miss_i = 1'b1;
			miss_pc_i = pc_i + ($urandom() % 22);
			run_cycle();
		end
		repeat (20)
		begin
			base_inputs();
			nop_i = 1'b1;
			run_cycle();
		end
		repeat (100)
		begin
			base_inputs();
			irq_req_i = 1'b1;
			mipv_i = ($urandom() % 4 == 0);
			run_cycle();
		end
		repeat (100)
		begin
			base_inputs();
			mipv_i = 1'b1;
			if ($urandom() % 3 == 0)
				mip_i = '0;
			run_cycle();
		end
		repeat (150)
		begin
			base_inputs();
			place_bsr();
			run_cycle();
		end
		// Mixed traffic with the enable dropping out
		repeat (200)
		begin
			base_inputs();
			place_bsr();
			en_i = ($urandom() % 3 != 0);
			nop_i = ($urandom() % 8 == 0);
			irq_req_i = ($urandom() % 6 == 0);
			mipv_i = ($urandom() % 6 == 0);
			branch_miss_i = ($urandom() % 4 == 0);
			miss_pc_i = pc_i + ($urandom() % 22);
			run_cycle();
		end
		apply_reset();
		repeat (20)
		begin
			base_inputs();
			run_cycle();
		end
		$display("All tests passed");
		$finish;
	end

endmodule

/* logic/ins_extract_top.sv */
// Top level of the four-wide instruction extract stage, instantiated by the front end
`timescale 1ns/10ps
`include "extract_consts.svh"

module ins_extract_top
(
	input  logic clk,
	input  logic rst_i,
	input  logic en_i,
	input  logic nop_i,
	input  logic irq_req_i,
	input  logic [2:0] irq_lvl_i,
	input  logic [7:0] irq_vect_i,
	input  logic mipv_i,
	input  extract_pkg::mip_t mip_i,
	input  extract_pkg::instruction_t mc_ins0_i,
	input  extract_pkg::instruction_t mc_ins1_i,
	input  extract_pkg::instruction_t mc_ins2_i,
	input  extract_pkg::instruction_t mc_ins3_i,
	input  logic [`EXT_LINE_W-1:0] line_i,
	input  extract_pkg::pc_t pc_i,
	input  logic branch_miss_i,
	input  extract_pkg::pc_t miss_pc_i,
	output extract_pkg::instruction_t ins0_o,
	output extract_pkg::instruction_t ins1_o,
	output extract_pkg::instruction_t ins2_o,
	output extract_pkg::instruction_t ins3_o,
	output extract_pkg::pc_t pc0_o,
	output extract_pkg::pc_t pc1_o,
	output extract_pkg::pc_t pc2_o,
	output extract_pkg::pc_t pc3_o,
	output logic [`EXT_REG_W-1:0] rt0_o,
	output logic [`EXT_REG_W-1:0] rt1_o,
	output logic [`EXT_REG_W-1:0] rt2_o,
	output logic [`EXT_REG_W-1:0] rt3_o,
	output logic [`EXT_REG_W-1:0] ra0_o,
	output logic [`EXT_REG_W-1:0] ra1_o,
	output logic [`EXT_REG_W-1:0] ra2_o,
	output logic [`EXT_REG_W-1:0] ra3_o,
	output logic dead0_o,
	output logic dead1_o,
	output logic dead2_o,
	output logic dead3_o,
	output extract_pkg::mip_t mcip0_o,
	output extract_pkg::mip_t mcip1_o,
	output extract_pkg::mip_t mcip2_o,
	output extract_pkg::mip_t mcip3_o,
	output logic nop_o,
	output logic do_bsr_o,
	output extract_pkg::pc_t bsr_tgt_o
);

	extract_pkg::instruction_t raw [0:`EXT_SLOTS-1];
	extract_pkg::pc_t slot_pc [0:`EXT_SLOTS-1];
	extract_pkg::instruction_t mc_ins [0:`EXT_SLOTS-1];

	slot_bus_if sb [0:`EXT_SLOTS-1] ();

	assign mc_ins[0] = mc_ins0_i;
	assign mc_ins[1] = mc_ins1_i;
	assign mc_ins[2] = mc_ins2_i;
	assign mc_ins[3] = mc_ins3_i;

	// ===================================================================
	// Align, select and register
	// ===================================================================

	line_aligner i_aligner
	(
		.line_i (line_i),
		.pc_i   (pc_i),
		.raw_o  (raw),
		.pc_o   (slot_pc)
	);

	generate
		for (genvar k = 0; k < `EXT_SLOTS; k++)
		begin : g_slot
			slot_mux #(.SLOT_IDX(k)) i_mux
			(
				.clk           (clk),
				.rst_i         (rst_i),
				.en_i          (en_i),
				.nop_i         (nop_i),
				.irq_req_i     (irq_req_i),
				.irq_lvl_i     (irq_lvl_i),
				.irq_vect_i    (irq_vect_i),
				.mipv_i        (mipv_i),
				.mip_i         (mip_i),
				.mc_ins_i      (mc_ins[k]),
				.raw_i         (raw[k]),
				.pc_i          (slot_pc[k]),
				.branch_miss_i (branch_miss_i),
				.miss_pc_i     (miss_pc_i),
				.bus           (sb[k])
			);
		end
	endgenerate

	// BSR search works on the registered slots
	bsr_detect i_bsr
	(
		.s0        (sb[0]),
		.s1        (sb[1]),
		.s2        (sb[2]),
		.s3        (sb[3]),
		.do_bsr_o  (do_bsr_o),
		.bsr_tgt_o (bsr_tgt_o)
	);

	// ===================================================================
	// Flattened slot outputs
	// ===================================================================

	assign ins0_o = sb[0].slot.ins;
	assign ins1_o = sb[1].slot.ins;
	assign ins2_o = sb[2].slot.ins;
	assign ins3_o = sb[3].slot.ins;
	assign pc0_o = sb[0].slot.pc;
	assign pc1_o = sb[1].slot.pc;
	assign pc2_o = sb[2].slot.pc;
	assign pc3_o = sb[3].slot.pc;
	assign rt0_o = sb[0].slot.aRt;
	assign rt1_o = sb[1].slot.aRt;
	assign rt2_o = sb[2].slot.aRt;
	assign rt3_o = sb[3].slot.aRt;
	assign ra0_o = sb[0].slot.aRa;
	assign ra1_o = sb[1].slot.aRa;
	assign ra2_o = sb[2].slot.aRa;
	assign ra3_o = sb[3].slot.aRa;
	assign dead0_o = sb[0].slot.dead;
	assign dead1_o = sb[1].slot.dead;
	assign dead2_o = sb[2].slot.dead;
	assign dead3_o = sb[3].slot.dead;
	assign mcip0_o = sb[0].mcip;
	assign mcip1_o = sb[1].mcip;
	assign mcip2_o = sb[2].mcip;
	assign mcip3_o = sb[3].mcip;

	// The whole group is a NOP only when every slot was killed
	assign nop_o = dead0_o & dead1_o & dead2_o & dead3_o;

endmodule

/* logic/bsr_detect.sv */
// Finds the first branch-to-subroutine among the registered slots and computes its target
`timescale 1ns/10ps
`include "extract_consts.svh"

module bsr_detect
(
	slot_bus_if.detect s0,
	slot_bus_if.detect s1,
	slot_bus_if.detect s2,
	slot_bus_if.detect s3,
	output logic do_bsr_o,
	output extract_pkg::pc_t bsr_tgt_o
);

	// The BSR displacement fills the instruction above this bit
	localparam int DISP_LSB = 10;
	localparam int DISP_W = `EXT_INS_W - DISP_LSB;
	localparam int INS_BYTES = `EXT_INS_W / 8;

	// Slot PC plus the sign-extended byte displacement
	function automatic extract_pkg::pc_t bsr_target(input extract_pkg::slot_t s);
		extract_pkg::pc_t disp;
		disp = {{(`EXT_PC_W-DISP_W){s.ins[`EXT_INS_W-1]}}, s.ins[`EXT_INS_W-1:DISP_LSB]};
		return s.pc + disp;
	endfunction

	// Each slot gets its own hit flag and target
	assign s0.do_bsr = s0.slot.ins.opcode == extract_pkg::OP_BSR;
	assign s1.do_bsr = s1.slot.ins.opcode == extract_pkg::OP_BSR;
	assign s2.do_bsr = s2.slot.ins.opcode == extract_pkg::OP_BSR;
	assign s3.do_bsr = s3.slot.ins.opcode == extract_pkg::OP_BSR;

	assign s0.bsr_tgt = bsr_target(s0.slot);
	assign s1.bsr_tgt = bsr_target(s1.slot);
	assign s2.bsr_tgt = bsr_target(s2.slot);
	assign s3.bsr_tgt = bsr_target(s3.slot);

	assign do_bsr_o = s0.do_bsr | s1.do_bsr | s2.do_bsr | s3.do_bsr;

	// The lowest slot wins, the later slots are skipped by the branch
	// Without a BSR the target is the fall-through PC after slot 3
	always_comb
	begin
		if (s0.do_bsr)
			bsr_tgt_o = s0.bsr_tgt;
		else if (s1.do_bsr)
			bsr_tgt_o = s1.bsr_tgt;
		else if (s2.do_bsr)
			bsr_tgt_o = s2.bsr_tgt;
		else if (s3.do_bsr)
			bsr_tgt_o = s3.bsr_tgt;
		else
			bsr_tgt_o = s3.slot.pc + extract_pkg::pc_t'(INS_BYTES);
	end

endmodule

/* logic/slot_mux.sv */
// Per-slot source select and slot register, instantiated once per slot by the extract top level
`timescale 1ns/10ps
`include "extract_consts.svh"

module slot_mux
#(
	parameter int SLOT_IDX = 0
)
(
	input  logic clk,
	input  logic rst_i,
	input  logic en_i,
	input  logic nop_i,
	input  logic irq_req_i,
	input  logic [2:0] irq_lvl_i,
	input  logic [7:0] irq_vect_i,
	input  logic mipv_i,
	input  extract_pkg::mip_t mip_i,
	input  extract_pkg::instruction_t mc_ins_i,
	input  extract_pkg::instruction_t raw_i,
	input  extract_pkg::pc_t pc_i,
	input  logic branch_miss_i,
	input  extract_pkg::pc_t miss_pc_i,
	slot_bus_if.source bus
);

	extract_pkg::instruction_t chk_ins;
	extract_pkg::instruction_t sel_ins;
	extract_pkg::slot_t slot_nxt;
	extract_pkg::mip_t mcip_nxt;
	logic kill;
	logic sel_dead;

	// ===================================================================
	// Source select
	// ===================================================================

	// CHK carries the interrupt level in the low bits of Rt and the vector
	// in the top byte of the instruction
	always_comb
	begin
		chk_ins = '0;
		chk_ins.opcode = extract_pkg::OP_CHK;
		chk_ins.rt = {{(`EXT_REG_W-3){1'b0}}, irq_lvl_i};
		chk_ins.imm = {irq_vect_i, 1'b0};
	end

	// A branch miss leaves every slot before the miss PC dead
	assign kill = nop_i || (branch_miss_i && (miss_pc_i > pc_i));

	// An interrupt is held off while micro-code is running
	always_comb
	begin
		sel_ins = raw_i;
		sel_dead = 1'b0;
		if (irq_req_i && !mipv_i)
			sel_ins = chk_ins;
		else if (mipv_i)
			sel_ins = mc_ins_i;
		else if (kill)
		begin
			sel_ins = '0;
			sel_dead = 1'b1;
		end
	end

	// Register fields follow whichever instruction was picked
	always_comb
	begin
		slot_nxt.ins = sel_ins;
		slot_nxt.pc = pc_i;
		slot_nxt.aRt = sel_ins.rt;
		slot_nxt.aRa = sel_ins.ra;
		slot_nxt.aRb = sel_ins.rb;
		slot_nxt.aRc = sel_ins.rc;
		slot_nxt.dead = sel_dead;
	end

	// Slots past the first step through the micro-code words by ORing in their index
	// A zero pointer means no micro-code and stays zero
	always_comb
	begin
		if (SLOT_IDX == 0 || mip_i == '0)
			mcip_nxt = mip_i;
		else
			mcip_nxt = mip_i | extract_pkg::mip_t'(SLOT_IDX);
	end

	// ===================================================================
	// Slot register
	// ===================================================================

	// Out of reset the slot is a dead NOP at PC zero
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			bus.slot <= '0;
			bus.slot.dead <= 1'b1;
			bus.mcip <= '0;
		end
		else if (en_i)
		begin
			bus.slot <= slot_nxt;
			bus.mcip <= mcip_nxt;
		end
	end

endmodule

/* logic/line_aligner.sv */
// Aligns a fetched cache line to the fetch PC and splits it into the raw slot instructions
`timescale 1ns/10ps
`include "extract_consts.svh"

module line_aligner
(
	input  logic [`EXT_LINE_W-1:0] line_i,
	input  extract_pkg::pc_t pc_i,
	output extract_pkg::instruction_t raw_o [0:`EXT_SLOTS-1],
	output extract_pkg::pc_t pc_o [0:`EXT_SLOTS-1]
);

	// Number of PC bits that address a byte within the line
	localparam int OFS_W = $clog2(`EXT_LINE_W / 8);

	// Every instruction has the same size, so slot PCs step by a constant
	localparam int INS_BYTES = `EXT_INS_W / 8;

	logic [OFS_W-1:0] byte_ofs;
	logic [`EXT_LINE_W-1:0] line_al;

	assign byte_ofs = pc_i[OFS_W-1:0];

	// Shift by whole bytes so that the byte the PC points to lands at bit zero
	// Bytes past the end of the line come in as zero
	assign line_al = line_i >> {byte_ofs, 3'd0};

	// ===================================================================
	// Slot split
	// ===================================================================

	generate
		for (genvar k = 0; k < `EXT_SLOTS; k++)
		begin : g_slot
			// Slot k sits k instructions past the PC
			assign raw_o[k] = line_al[k*`EXT_INS_W +: `EXT_INS_W];
			assign pc_o[k] = pc_i + extract_pkg::pc_t'(k * INS_BYTES);
		end
	endgenerate

endmodule

/* logic/slot_bus_if.sv */
// Bus for one registered slot, from its slot mux to the BSR detector and the top level
`timescale 1ns/10ps

interface slot_bus_if;

	// Registered slot and its micro-code pointer, driven by the slot mux
	extract_pkg::slot_t slot;
	extract_pkg::mip_t mcip;

	// Per-slot BSR hit and target, filled in by the detector
	logic do_bsr;
	extract_pkg::pc_t bsr_tgt;

	// Slot mux side
	modport source
	(
		output slot,
		output mcip
	);

	// BSR detector side
	modport detect
	(
		input  slot,
		output do_bsr,
		output bsr_tgt
	);

	// Consumer of the registered slot
	modport sink
	(
		input slot,
		input mcip
	);

endinterface

/* logic/extract_pkg.sv */
// Shared types of the extract stage, referenced by scoped name from every RTL file
`include "extract_consts.svh"

package extract_pkg;

	// Major opcodes seen by the extract stage
	// NOP must stay at zero so that an all-zero instruction decodes as NOP
	typedef enum logic [6:0]
	{
		OP_NOP   = 7'h00,
		OP_CHK   = 7'h01,
		OP_BSR   = 7'h02,
		OP_ADD   = 7'h04,
		OP_SUB   = 7'h05,
		OP_AND   = 7'h08,
		OP_OR    = 7'h09,
		OP_LOAD  = 7'h10,
		OP_STORE = 7'h11
	} opcode_e;

	// Five-byte instruction with the opcode in the low bits
	// BSR reuses bits 39 to 10 as a signed byte displacement
	typedef struct packed
	{
		logic [`EXT_INS_W-8-4*`EXT_REG_W:0] imm;
		logic [`EXT_REG_W-1:0] rc;
		logic [`EXT_REG_W-1:0] rb;
		logic [`EXT_REG_W-1:0] ra;
		logic [`EXT_REG_W-1:0] rt;
		opcode_e opcode;
	} instruction_t;

	typedef logic [`EXT_PC_W-1:0] pc_t;

	typedef logic [`EXT_MIP_W-1:0] mip_t;

	// One registered slot as handed on to decode
	// The dead flag marks a slot that was turned into a NOP
	typedef struct packed
	{
		instruction_t ins;
		pc_t pc;
		logic [`EXT_REG_W-1:0] aRt;
		logic [`EXT_REG_W-1:0] aRa;
		logic [`EXT_REG_W-1:0] aRb;
		logic [`EXT_REG_W-1:0] aRc;
		logic dead;
	} slot_t;

endpackage

/* include/extract_consts.svh */
// Width constants for the instruction extract stage, included by the package, the RTL and the testbench
`ifndef EXTRACT_CONSTS_SVH
`define EXTRACT_CONSTS_SVH

// Instruction-cache line as delivered by the fetch unit
`define EXT_LINE_W 512

// One instruction is five bytes wide
`define EXT_INS_W 40

// Byte address width of the fetch and slot PCs
`define EXT_PC_W 32

// Architectural register number
`define EXT_REG_W 6

// Micro-code instruction pointer
`define EXT_MIP_W 12

// Instructions extracted per cycle
`define EXT_SLOTS 4

`endif
